// ==== common/armStatusPkg.sv ====
`default_nettype none

package armStatusPkg;

  // Width of the ALU result field carried in aluOutcomeT
  localparam int resultWidth = 32;

  // Bit positions in the 6-bit exceptions request vector,
  // ordered from the top: Fiq, Irq, Undefined, PrefetchAbort, DataAbort, SoftwareInt
  localparam int excBitFiq           = 5;
  localparam int excBitIrq           = 4;
  localparam int excBitUndefined     = 3;
  localparam int excBitPrefetchAbort = 2;
  localparam int excBitDataAbort     = 1;
  localparam int excBitSoftwareInt   = 0;

  // SPSR bank indices
  localparam logic [2:0] bankSupervisor = 3'd0;
  localparam logic [2:0] bankAbort      = 3'd1;
  localparam logic [2:0] bankUndefined  = 3'd2;
  localparam logic [2:0] bankIrq        = 3'd3;
  localparam logic [2:0] bankFiq        = 3'd4;

  typedef enum logic [4:0] {
    modeUser       = 5'b10000,
    modeFiq        = 5'b10001,
    modeIrq        = 5'b10010,
    modeSupervisor = 5'b10011,
    modeAbort      = 5'b10111,
    modeUndefined  = 5'b11011,
    modeSystem     = 5'b11111
  } modeT;

  typedef enum logic [2:0] {
    excNone,
    excDataAbort,
    excFiq,
    excIrq,
    excPrefetchAbort,
    excUndefined,
    excSoftwareInt
  } exceptionT;

  typedef enum logic [1:0] {
    opLogical,
    opArithmetic,
    opMultiply,
    opNoFlags
  } aluOpT;

  typedef struct packed {
    logic [3:0] flags;  // N Z C V, N on top
    logic       irqDisable;
    logic       fiqDisable;
    logic       thumb;  // 0 ARM, 1 Thumb
    modeT       mode;
  } statusWordT;

  typedef struct packed {
    logic [resultWidth-1:0] result;
    logic                   carryOut;     // Adder carry
    logic                   overflow;     // Signed overflow
    logic                   shifterCarry; // Barrel shifter carry out
    aluOpT                  op;
  } aluOutcomeT;

  typedef struct packed {
    logic        valid;
    exceptionT   kind;
    modeT        newMode;
    logic [2:0]  bank;          // SPSR bank receiving old CPSR
    logic [31:0] vector;
    logic        setFiqDisable; // FIQ entry only
  } exceptionEntryT;

  typedef struct packed {
    logic       toSpsr;       // Target current SPSR instead of CPSR
    logic       writeFlags;   // Flags field
    logic       writeControl; // Disable bits, thumb, mode
    statusWordT data;
  } srWriteT;

  // True for any encoding listed in modeT
  function automatic logic legalMode(modeT m);
    case (m)
      modeUser, modeFiq, modeIrq, modeSupervisor,
      modeAbort, modeUndefined, modeSystem: return 1'b1;
      default:                              return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== flags/flagUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module flagUnit #(
  parameter int dataWidth = 32
) (
  input  armStatusPkg::aluOutcomeT aluOutcome,
  input  logic [3:0]               currentFlags, // N Z C V
  output logic [3:0]               flagsNext
);

  import armStatusPkg::*;

  // Result slice must fit the package result field
  if (dataWidth < 1 || dataWidth > resultWidth) begin : gWidthCheck
    $error("flagUnit dataWidth out of range");
  end

  logic [dataWidth-1:0] result;
  logic                 resultNeg;
  logic                 resultZero;
  logic                 oldN;
  logic                 oldZ;
  logic                 oldC;
  logic                 oldV;
  logic                 n;
  logic                 z;
  logic                 c;
  logic                 v;

  assign result     = aluOutcome.result[dataWidth-1:0]; // Only the live width
  assign resultNeg  = result[dataWidth-1];              // Sign bit
  assign resultZero = ~|result;

  assign {oldN, oldZ, oldC, oldV} = currentFlags;

  always_comb begin
    // N and Z come from the result unless the op sets nothing
    n = resultNeg;
    z = resultZero;
    c = oldC;
    v = oldV;
    case (aluOutcome.op)
      opArithmetic: begin
        c = aluOutcome.carryOut; // Adder carry / not borrow
        v = aluOutcome.overflow;
      end
      opLogical: begin
        c = aluOutcome.shifterCarry; // Shifter carry, V kept
      end
      opMultiply: begin
        // C and V kept
      end
      opNoFlags: begin
        n = oldN; // Nothing changes
        z = oldZ;
      end
      default: begin
        n = oldN;
        z = oldZ;
      end
    endcase
  end

  assign flagsNext = {n, z, c, v};

endmodule

`default_nettype wire

// ==== exception/exceptionArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module exceptionArbiter #(
  parameter logic [31:0] vectorBase = 32'h0000_0000
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [5:0]                   exceptions,
  input  armStatusPkg::statusWordT     cpsr,
  output armStatusPkg::exceptionEntryT entry
);

  import armStatusPkg::*;

  // Offsets from the vector base
  localparam logic [31:0] offUndefined     = 32'h04;
  localparam logic [31:0] offSoftwareInt   = 32'h08;
  localparam logic [31:0] offPrefetchAbort = 32'h0C;
  localparam logic [31:0] offDataAbort     = 32'h10;
  localparam logic [31:0] offIrq           = 32'h18;
  localparam logic [31:0] offFiq           = 32'h1C;

  logic        fiqReq;
  logic        irqReq;
  logic        undefinedReq;
  logic        prefetchReq;
  logic        dataAbortReq;
  logic        softwareReq;
  logic [31:0] offset;

  assign fiqReq       = exceptions[excBitFiq] & ~cpsr.fiqDisable; // Masked by F
  assign irqReq       = exceptions[excBitIrq] & ~cpsr.irqDisable; // Masked by I
  assign undefinedReq = exceptions[excBitUndefined];
  assign prefetchReq  = exceptions[excBitPrefetchAbort];
  assign dataAbortReq = exceptions[excBitDataAbort];
  assign softwareReq  = exceptions[excBitSoftwareInt];

  always_comb begin
    entry       = '0;
    entry.kind    = excNone;
    entry.newMode = cpsr.mode; // Don't care while not valid
    offset      = '0;
    // Fixed priority, data abort first
    if (dataAbortReq) begin
      entry.kind    = excDataAbort;
      entry.newMode = modeAbort;
      entry.bank    = bankAbort;
      offset        = offDataAbort;
    end else if (fiqReq) begin
      entry.kind          = excFiq;
      entry.newMode       = modeFiq;
      entry.bank          = bankFiq;
      entry.setFiqDisable = 1'b1; // Only FIQ masks further FIQs
      offset              = offFiq;
    end else if (irqReq) begin
      entry.kind    = excIrq;
      entry.newMode = modeIrq;
      entry.bank    = bankIrq;
      offset        = offIrq;
    end else if (prefetchReq) begin
      entry.kind    = excPrefetchAbort;
      entry.newMode = modeAbort; // Shares the abort bank
      entry.bank    = bankAbort;
      offset        = offPrefetchAbort;
    end else if (undefinedReq) begin
      entry.kind    = excUndefined;
      entry.newMode = modeUndefined;
      entry.bank    = bankUndefined;
      offset        = offUndefined;
    end else if (softwareReq) begin
      entry.kind    = excSoftwareInt;
      entry.newMode = modeSupervisor;
      entry.bank    = bankSupervisor;
      offset        = offSoftwareInt;
    end
    entry.valid  = (entry.kind != excNone);
    entry.vector = vectorBase + offset; // High or low vectors
  end

  // Entry always lands in a privileged exception mode
  assert property (@(posedge clk) disable iff (reset)
    entry.valid |-> legalMode(entry.newMode)
                    && entry.newMode != modeUser && entry.newMode != modeSystem)
    else $error("exceptionArbiter: illegal entry mode %b", entry.newMode);

  // I bit held by the status bank blocks IRQ
  assert property (@(posedge clk) disable iff (reset)
    (exceptions[excBitIrq] && cpsr.irqDisable) |-> entry.kind != excIrq)
    else $error("exceptionArbiter: masked IRQ taken");

endmodule

`default_nettype wire

// ==== statusBank/statusBank.sv ====
`timescale 1ns/1ns
`default_nettype none

module statusBank (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [3:0]                   flagsNext,
  input  logic                         setFlags,
  input  logic                         enable,    // Instruction retire
  input  logic                         thumbNext,
  input  armStatusPkg::exceptionEntryT entry,
  input  logic                         writeSR,
  input  armStatusPkg::srWriteT        srWrite,
  input  logic                         restoreSR, // Exception return
  input  logic                         readSpsr,
  output armStatusPkg::statusWordT     cpsr,
  output armStatusPkg::statusWordT     srData
);

  import armStatusPkg::*;

  // Supervisor, IRQ and FIQ off, ARM state, flags clear
  localparam statusWordT resetWord = '{
    flags:      4'b0000,
    irqDisable: 1'b1,
    fiqDisable: 1'b1,
    thumb:      1'b0,
    mode:       modeSupervisor
  };

  statusWordT spsr [5];  // SVC, ABT, UND, IRQ, FIQ
  statusWordT spsrCur;
  statusWordT cpsrNext;
  statusWordT spsrNext;
  logic [2:0] curBank;
  logic       hasSpsr;   // Low in User and System
  logic       spsrWe;
  logic [2:0] spsrIdx;

  // Field-masked status write
  function automatic statusWordT applyWrite(statusWordT old, srWriteT w);
    statusWordT res;
    res = old;
    if (w.writeFlags) begin
      res.flags = w.data.flags;
    end
    if (w.writeControl) begin
      res.irqDisable = w.data.irqDisable;
      res.fiqDisable = w.data.fiqDisable;
      res.thumb      = w.data.thumb;
      res.mode       = w.data.mode;
    end
    return res;
  endfunction

  // Current mode to SPSR bank
  always_comb begin
    hasSpsr = 1'b1;
    curBank = bankSupervisor;
    case (cpsr.mode)
      modeSupervisor: curBank = bankSupervisor;
      modeAbort:      curBank = bankAbort;
      modeUndefined:  curBank = bankUndefined;
      modeIrq:        curBank = bankIrq;
      modeFiq:        curBank = bankFiq;
      default:        hasSpsr = 1'b0; // User, System
    endcase
  end

  assign spsrCur = spsr[curBank];

  // One update per cycle, highest priority first
  always_comb begin
    cpsrNext = cpsr;
    spsrNext = cpsr;
    spsrIdx  = curBank;
    spsrWe   = 1'b0;
    if (entry.valid) begin
      spsrWe              = 1'b1;            // Save old CPSR
      spsrIdx             = entry.bank;
      spsrNext            = cpsr;
      cpsrNext.irqDisable = 1'b1;
      cpsrNext.fiqDisable = cpsr.fiqDisable | entry.setFiqDisable;
      cpsrNext.thumb      = 1'b0;            // Handlers run in ARM state
      cpsrNext.mode       = entry.newMode;   // Flags kept
    end else if (writeSR) begin
      if (srWrite.toSpsr) begin
        spsrWe   = hasSpsr;                  // Dropped without an SPSR
        spsrNext = applyWrite(spsrCur, srWrite);
      end else begin
        cpsrNext = applyWrite(cpsr, srWrite);
      end
    end else if (restoreSR) begin
      if (hasSpsr) begin
        cpsrNext = spsrCur;
      end
    end else if (enable) begin
      cpsrNext.thumb = thumbNext;
      if (setFlags) begin
        cpsrNext.flags = flagsNext;
      end
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      cpsr <= resetWord;
    end else begin
      cpsr <= cpsrNext;
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 5; i++) begin
        spsr[i] <= '0;
      end
    end else if (spsrWe) begin
      spsr[spsrIdx] <= spsrNext;
    end
  end

  // SPSR read falls back to CPSR in User and System
  assign srData = (readSpsr && hasSpsr) ? spsrCur : cpsr;

  // Mode field never leaves the legal set
  assert property (@(posedge clk) disable iff (reset)
    legalMode(cpsr.mode))
    else $error("statusBank: illegal CPSR mode %b", cpsr.mode);

  // Arbiter entry always masks IRQ on the next cycle
  assert property (@(posedge clk) disable iff (reset)
    entry.valid |=> cpsr.irqDisable)
    else $error("statusBank: IRQ not disabled after entry");

endmodule

`default_nettype wire

// ==== source/statusControl.sv ====
`timescale 1ns/1ns
`default_nettype none

module statusControl #(
  parameter int          dataWidth  = 32,
  parameter logic [31:0] vectorBase = 32'h0000_0000  // FFFF0000 for high vectors
) (
  input  logic                     clk,
  input  logic                     reset,
  input  armStatusPkg::aluOutcomeT aluOutcome,
  input  logic                     setFlags,
  input  logic                     enable,
  input  logic                     thumbNext,
  input  logic [5:0]               exceptions,
  input  logic                     writeSR,
  input  armStatusPkg::srWriteT    srWrite,
  input  logic                     restoreSR,
  input  logic                     readSpsr,
  output armStatusPkg::statusWordT srData,
  output armStatusPkg::statusWordT cpsr,
  output logic                     exceptionTaken,
  output logic [31:0]              vector
);

  import armStatusPkg::*;

  logic [3:0]     flagsNext;
  exceptionEntryT entry;

  flagUnit #(
    .dataWidth (dataWidth)
  ) u_flagUnit (
    .aluOutcome   (aluOutcome),
    .currentFlags (cpsr.flags),
    .flagsNext    (flagsNext)
  );

  exceptionArbiter #(
    .vectorBase (vectorBase)
  ) u_exceptionArbiter (
    .clk        (clk),
    .reset      (reset),
    .exceptions (exceptions),
    .cpsr       (cpsr),
    .entry      (entry)
  );

  statusBank u_statusBank (
    .clk       (clk),
    .reset     (reset),
    .flagsNext (flagsNext),
    .setFlags  (setFlags),
    .enable    (enable),
    .thumbNext (thumbNext),
    .entry     (entry),
    .writeSR   (writeSR),
    .srWrite   (srWrite),
    .restoreSR (restoreSR),
    .readSpsr  (readSpsr),
    .cpsr      (cpsr),
    .srData    (srData)
  );

  assign exceptionTaken = entry.valid;  // Same cycle as the request
  assign vector         = entry.vector;

endmodule

`default_nettype wire

// ==== bench/clockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
  parameter int periodNs    = 4,
  parameter int resetCycles = 3
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(periodNs / 2) clk = ~clk; // 50% duty
  end

  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk); // Release away from the active edge
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/statusControlTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module statusControlTb;

  import armStatusPkg::*;

  localparam int          dataWidth  = 32;
  localparam logic [31:0] vectorBase = 32'hFFFF_0000; // High vectors
  localparam int          periodNs   = 4;
  localparam int          flagCycles = 40;
  localparam int          excPairs   = 40;
  localparam int          plannedCycles = 3 + flagCycles + 2 * excPairs + 5 * 11 + 2 * 4 + 4;
  localparam int          timeoutNs  = plannedCycles * periodNs + 200; // Plus margin

  // Supervisor, IRQ and FIQ off, ARM state, flags clear
  localparam statusWordT resetState = '{
    flags:      4'b0000,
    irqDisable: 1'b1,
    fiqDisable: 1'b1,
    thumb:      1'b0,
    mode:       modeSupervisor
  };

  logic        clk;
  logic        reset;
  aluOutcomeT  aluOutcome;
  logic        setFlags;
  logic        enable;
  logic        thumbNext;
  logic [5:0]  exceptions; // Fiq Irq Und Pabt Dabt Swi
  logic        writeSR;
  srWriteT     srWrite;
  logic        restoreSR;
  logic        readSpsr;
  statusWordT  srData;
  statusWordT  cpsr;
  logic        exceptionTaken;
  logic [31:0] vector;

  // Reference model state
  statusWordT  modelCpsr;
  statusWordT  modelSpsr [5]; // SVC ABT UND IRQ FIQ
  logic [2:0]  curBank;
  logic        curHasSpsr;
  logic [5:0]  pending;
  logic        expTaken;
  logic [2:0]  winnerBit;
  modeT        expMode;
  logic [2:0]  expBank;
  logic [31:0] expOffset;
  logic [31:0] expVector;
  logic        expSetF;
  statusWordT  expSrData;

  clockGen #(
    .periodNs    (periodNs),
    .resetCycles (3)
  ) u_clockGen (
    .clk   (clk),
    .reset (reset)
  );

  statusControl #(
    .dataWidth  (dataWidth),
    .vectorBase (vectorBase)
  ) u_statusControl (
    .clk            (clk),
    .reset          (reset),
    .aluOutcome     (aluOutcome),
    .setFlags       (setFlags),
    .enable         (enable),
    .thumbNext      (thumbNext),
    .exceptions     (exceptions),
    .writeSR        (writeSR),
    .srWrite        (srWrite),
    .restoreSR      (restoreSR),
    .readSpsr       (readSpsr),
    .srData         (srData),
    .cpsr           (cpsr),
    .exceptionTaken (exceptionTaken),
    .vector         (vector)
  );

  // Request bit for each priority rank, rank 0 wins
  function automatic logic [2:0] bitOfRank(int rank);
    case (rank)
      0:       return 3'd1; // Data abort
      1:       return 3'd5; // FIQ
      2:       return 3'd4; // IRQ
      3:       return 3'd2; // Prefetch abort
      4:       return 3'd3; // Undefined
      default: return 3'd0; // SWI
    endcase
  endfunction

  // N Z C V after one ALU op
  function automatic logic [3:0] predictFlags(aluOutcomeT a, logic [3:0] old);
    logic [3:0] res;
    res = old;
    if (a.op != opNoFlags) begin
      res[3] = a.result[dataWidth-1];
      res[2] = (a.result[dataWidth-1:0] == '0);
    end
    if (a.op == opArithmetic) begin
      res[1] = a.carryOut;
      res[0] = a.overflow;
    end else if (a.op == opLogical) begin
      res[1] = a.shifterCarry; // V untouched
    end
    return res;
  endfunction

  // Fields selected by the write masks come from the new data
  function automatic statusWordT mergeFields(statusWordT old, srWriteT w);
    logic [11:0] keep;
    keep = {{4{~w.writeFlags}}, {8{~w.writeControl}}};
    return statusWordT'((old & keep) | (w.data & ~keep));
  endfunction

  function automatic modeT randomMode();
    logic [2:0] pick;
    pick = 3'($urandom_range(6, 0));
    case (pick)
      3'd0:    return modeUser;
      3'd1:    return modeFiq;
      3'd2:    return modeIrq;
      3'd3:    return modeSupervisor;
      3'd4:    return modeAbort;
      3'd5:    return modeUndefined;
      default: return modeSystem;
    endcase
  endfunction

  function automatic statusWordT randomWord(modeT m);
    statusWordT w;
    logic [31:0] r;
    r = $urandom;
    w.flags      = r[3:0];
    w.irqDisable = r[4];
    w.fiqDisable = r[5];
    w.thumb      = r[6];
    w.mode       = m; // Always legal
    return w;
  endfunction

  // SPSR bank of the current mode
  always_comb begin
    curHasSpsr = 1'b1;
    curBank    = 3'd0;
    case (modelCpsr.mode)
      modeSupervisor: curBank = 3'd0;
      modeAbort:      curBank = 3'd1;
      modeUndefined:  curBank = 3'd2;
      modeIrq:        curBank = 3'd3;
      modeFiq:        curBank = 3'd4;
      default:        curHasSpsr = 1'b0; // User, System
    endcase
  end

  // Expected arbitration
  always_comb begin
    pending   = exceptions & ~{modelCpsr.fiqDisable, modelCpsr.irqDisable, 4'b0000};
    expTaken  = 1'b0;
    winnerBit = 3'd0;
    for (int rank = 5; rank >= 0; rank--) begin
      if (pending[bitOfRank(rank)]) begin // Higher rank overwrites
        expTaken  = 1'b1;
        winnerBit = bitOfRank(rank);
      end
    end
    expMode   = modelCpsr.mode;
    expBank   = 3'd0;
    expOffset = 32'h0;
    expSetF   = 1'b0;
    if (expTaken) begin
      case (winnerBit)
        3'd5: begin
          expMode   = modeFiq;
          expBank   = 3'd4;
          expOffset = 32'h1C;
          expSetF   = 1'b1;
        end
        3'd4: begin
          expMode   = modeIrq;
          expBank   = 3'd3;
          expOffset = 32'h18;
        end
        3'd3: begin
          expMode   = modeUndefined;
          expBank   = 3'd2;
          expOffset = 32'h04;
        end
        3'd2: begin
          expMode   = modeAbort;
          expBank   = 3'd1;
          expOffset = 32'h0C;
        end
        3'd1: begin
          expMode   = modeAbort;
          expBank   = 3'd1;
          expOffset = 32'h10;
        end
        default: begin
          expMode   = modeSupervisor; // SWI
          expBank   = 3'd0;
          expOffset = 32'h08;
        end
      endcase
    end
    expVector = vectorBase + expOffset;
  end

  assign expSrData = (readSpsr && curHasSpsr) ? modelSpsr[curBank] : modelCpsr;

  // Cycle model of the registers
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      modelCpsr <= resetState;
      for (int i = 0; i < 5; i++) begin
        modelSpsr[i] <= '0;
      end
    end else if (expTaken) begin
      modelSpsr[expBank]   <= modelCpsr; // Old CPSR saved
      modelCpsr.irqDisable <= 1'b1;
      if (expSetF) begin
        modelCpsr.fiqDisable <= 1'b1;
      end
      modelCpsr.thumb <= 1'b0;
      modelCpsr.mode  <= expMode;
    end else if (writeSR) begin
      if (!srWrite.toSpsr) begin
        modelCpsr <= mergeFields(modelCpsr, srWrite);
      end else if (curHasSpsr) begin
        modelSpsr[curBank] <= mergeFields(modelSpsr[curBank], srWrite);
      end
    end else if (restoreSR) begin
      if (curHasSpsr) begin
        modelCpsr <= modelSpsr[curBank];
      end
    end else if (enable) begin
      modelCpsr.thumb <= thumbNext;
      if (setFlags) begin
        modelCpsr.flags <= predictFlags(aluOutcome, modelCpsr.flags);
      end
    end
  end

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1);
  endtask

  assert property (@(posedge clk) $fell(reset) |-> cpsr == resetState)
    else failRun($sformatf("MISMATCH time=%0t signal=cpsr after reset dut=%h expected=%h",
                           $time, $sampled(cpsr), resetState));

  assert property (@(posedge clk) disable iff (reset) cpsr == modelCpsr)
    else failRun($sformatf("MISMATCH time=%0t signal=cpsr dut=%h expected=%h",
                           $time, $sampled(cpsr), $sampled(modelCpsr)));

  assert property (@(posedge clk) disable iff (reset) srData == expSrData)
    else failRun($sformatf("MISMATCH time=%0t signal=srData dut=%h expected=%h",
                           $time, $sampled(srData), $sampled(expSrData)));

  assert property (@(posedge clk) disable iff (reset) exceptionTaken == expTaken)
    else failRun($sformatf("MISMATCH time=%0t signal=exceptionTaken dut=%b expected=%b",
                           $time, $sampled(exceptionTaken), $sampled(expTaken)));

  // Vector only meaningful with a winner
  assert property (@(posedge clk) disable iff (reset) expTaken |-> vector == expVector)
    else failRun($sformatf("MISMATCH time=%0t signal=vector dut=%h expected=%h",
                           $time, $sampled(vector), $sampled(expVector)));

  task automatic clearInputs();
    setFlags   = 1'b0;
    enable     = 1'b0;
    thumbNext  = 1'b0;
    exceptions = 6'b000000;
    writeSR    = 1'b0;
    srWrite    = '0;
    restoreSR  = 1'b0;
    readSpsr   = 1'b0;
  endtask

  task automatic startCycle();
    @(negedge clk); // Inputs settle well before the next rising edge
    clearInputs();
  endtask

  task automatic flagCycle();
    logic [31:0] r;
    startCycle();
    r = $urandom;
    aluOutcome.result       = (r[1:0] == 2'b00) ? 32'h0 : $urandom; // Some zeros for Z
    aluOutcome.carryOut     = r[2];
    aluOutcome.overflow     = r[3];
    aluOutcome.shifterCarry = r[4];
    aluOutcome.op           = aluOpT'(r[6:5]);
    setFlags                = r[7] | r[8];
    enable                  = r[9] | r[10] | r[11]; // Mostly retiring
    thumbNext               = r[12];
  endtask

  task automatic exceptionCycle();
    logic [31:0] r;
    startCycle();
    r          = $urandom;
    exceptions = (r[8:7] == 2'b00) ? 6'b000000 : r[5:0];
    readSpsr   = r[6];
  endtask

  task automatic writeStatus(input logic toSpsr, input logic [1:0] fields,
                             input statusWordT data, input logic readBack);
    startCycle();
    writeSR              = 1'b1;
    srWrite.toSpsr       = toSpsr;
    srWrite.writeFlags   = fields[1];
    srWrite.writeControl = fields[0];
    srWrite.data         = data;
    readSpsr             = readBack;
  endtask

  task automatic restoreStatus();
    startCycle();
    restoreSR = 1'b1;
    readSpsr  = 1'b1;
  endtask

  // SPSR fill, masked writes, CPSR writes and return in one mode
  task automatic exerciseBank(input modeT m);
    writeStatus(1'b0, 2'b11, randomWord(m), 1'b0);
    writeStatus(1'b1, 2'b11, randomWord(randomMode()), 1'b1);
    for (int f = 0; f < 4; f++) begin
      writeStatus(1'b1, 2'(f), randomWord(randomMode()), 1'b1);
    end
    for (int f = 0; f < 4; f++) begin
      writeStatus(1'b0, 2'(f), randomWord(m), 1'b1); // Stay in m
    end
    restoreStatus();
  endtask

  // User and System have no SPSR
  task automatic probeNoSpsr(input modeT m);
    writeStatus(1'b0, 2'b11, randomWord(m), 1'b0);
    writeStatus(1'b1, 2'b11, randomWord(randomMode()), 1'b1);
    restoreStatus();
    startCycle();
    readSpsr = 1'b1;
  endtask

  initial begin
    #(timeoutNs);
    failRun($sformatf("Timeout: simulation did not finish within %0d ns", timeoutNs));
  end

  initial begin
    logic [31:0] r;
    void'($urandom(32'h2d4a));
    aluOutcome = '0;
    clearInputs();
    @(negedge reset);

    repeat (flagCycles) begin
      flagCycle();
    end

    // Open or close I and F, then raise requests
    repeat (excPairs) begin
      r = $urandom;
      writeStatus(1'b0, {r[0], 1'b1}, randomWord(randomMode()), 1'b1);
      exceptionCycle();
    end

    exerciseBank(modeSupervisor);
    exerciseBank(modeAbort);
    exerciseBank(modeUndefined);
    exerciseBank(modeIrq);
    exerciseBank(modeFiq);
    probeNoSpsr(modeUser);
    probeNoSpsr(modeSystem);

    repeat (3) begin
      startCycle();
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
common/armStatusPkg.sv
flags/flagUnit.sv
exception/exceptionArbiter.sv
statusBank/statusBank.sv
source/statusControl.sv
bench/clockGen.sv
bench/statusControlTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the statusControl testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module statusControlTb \
  -f sources.f \
  -o statusControlSim

# Exit status of the simulator is not trusted; the log decides
./obj_dir/statusControlSim 2>&1 | tee sim.log || true

if grep -q "tests failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

if ! grep -q "all tests passed" sim.log; then
  echo "Simulation ended without a result line, see sim.log"
  exit 1
fi

echo "Simulation clean"
